/* verilog.f */
issue_pkg.sv
issue_decoder.sv
operand_fetch.sv
operand_select.sv
issue_ctrl.sv
issue_logic.sv
tb_issue_logic.sv

/* Bender.yml */
package:
  name: issue_logic

sources:
  - issue_pkg.sv
  - issue_decoder.sv
  - operand_fetch.sv
  - operand_select.sv
  - issue_ctrl.sv
  - issue_logic.sv
  - target: test
    files:
      - tb_issue_logic.sv

/* tb_issue_logic.sv */
module tb_issue_logic import issue_pkg::*; ();

    localparam int ROB_IDX_LEN = 6;
    localparam int VECTORS     = 30;                           // vectors per test
    localparam int N_TESTS     = 6;
    localparam int CYCLE_LIMIT = 4 + N_TESTS * 40 + 20;

    logic clk = 1'b0;
    logic reset_i;
    int   error_count = 0;
    int   cycle_count = 0;

    // DUT inputs, named as the ports so .* connects them
    logic                   iq_valid_i, regstat_ready_i, rob_ready_i;
    iq_entry_t              iq_entry_i;
    logic                   regstat_rs1_busy_i, regstat_rs2_busy_i;
    logic [ROB_IDX_LEN-1:0] regstat_rs1_rob_idx_i, regstat_rs2_rob_idx_i;
    logic [XLEN-1:0]        rf_rs1_value_i, rf_rs2_value_i;
    logic [EU_N-1:0]        ex_ready_i;
    logic                   rob_rs1_ready_i, rob_rs2_ready_i;
    logic [XLEN-1:0]        rob_rs1_value_i, rob_rs2_value_i, cdb_value_i;
    logic [ROB_IDX_LEN-1:0] rob_tail_idx_i, cdb_rob_idx_i;
    logic                   cdb_except_raised_i;
    // DUT outputs
    logic                   iq_ready_o, regstat_valid_o, rob_valid_o, main_cu_stall_o;
    logic [REG_IDX_LEN-1:0] regstat_rd_idx_o, regstat_rs1_idx_o, regstat_rs2_idx_o;
    logic [REG_IDX_LEN-1:0] rf_rs1_idx_o, rf_rs2_idx_o, rob_rd_idx_o;
    logic [ROB_IDX_LEN-1:0] regstat_rob_idx_o, ex_rs1_idx_o, ex_rs2_idx_o, ex_rob_idx_o;
    logic [ROB_IDX_LEN-1:0] rob_rs1_idx_o, rob_rs2_idx_o;
    logic [EU_N-1:0]        ex_valid_o;
    logic [EU_CTL_LEN-1:0]  ex_eu_ctl_o;
    logic                   ex_rs1_ready_o, ex_rs2_ready_o, ex_pred_taken_o;
    logic [XLEN-1:0]        ex_rs1_value_o, ex_rs2_value_o, ex_pred_pc_o, ex_pred_target_o;
    logic [I_IMM-1:0]       ex_imm_value_o;
    logic [ILEN-1:0]        rob_instr_o;
    logic                   rob_except_raised_o, rob_res_ready_o;
    except_code_t           rob_except_code_o;
    logic [XLEN-1:0]        rob_except_aux_o;

    // expected decode, worked out from the opcode rules
    logic [ILEN-1:0]       cur_instr;
    int                    ref_eu;             // -1 means ROB only
    logic [EU_CTL_LEN-1:0] ref_ctl;
    logic                  ref_rd_write, ref_rs1_req, ref_rs2_req, ref_imm_req;
    imm_format_t           ref_imm_fmt;
    logic                  ref_exc, ref_res_ready, ref_stall;
    logic [3:0]            ref_code;

    issue_logic #(.ROB_IDX_LEN(ROB_IDX_LEN)) i_dut (.*);

    always #10 clk = ~clk;

    assign cur_instr = iq_entry_i.instr;

    always @* begin
        ref_eu        = -1;
        ref_ctl       = {5'b0, cur_instr[14:12]};   // funct3 low
        ref_rd_write  = 1'b0;
        ref_rs1_req   = 1'b0;
        ref_rs2_req   = 1'b0;
        ref_imm_req   = 1'b0;
        ref_imm_fmt   = IMM_I;
        ref_exc       = 1'b0;
        ref_code      = E_ILLEGAL_INSTR;
        ref_res_ready = 1'b0;
        ref_stall     = 1'b0;
        case (cur_instr[6:0])
            LOAD: begin
                ref_eu       = 0;
                ref_rs1_req  = 1'b1;
                ref_imm_req  = 1'b1;
                ref_rd_write = 1'b1;
            end
            STORE, BRANCH: begin   // both read two sources, no rd
                ref_eu      = (cur_instr[6:0] == STORE) ? 1 : 2;
                ref_rs1_req = 1'b1;
                ref_rs2_req = 1'b1;
                ref_imm_req = 1'b1;
                ref_imm_fmt = (cur_instr[6:0] == STORE) ? IMM_S : IMM_B;
            end
            OP_IMM: begin
                ref_eu       = 3;
                ref_rs1_req  = 1'b1;
                ref_imm_req  = 1'b1;
                ref_rd_write = 1'b1;
                if (cur_instr[13:12] == 2'b01) begin   // slli / srli / srai
                    ref_imm_fmt = IMM_SHAMT;
                    ref_ctl[3]  = cur_instr[30];
                end
            end
            OP: begin
                ref_ctl[3] = cur_instr[30];
                if (cur_instr[31:25] == 7'b0000001 || cur_instr[31:25] == 7'b0000000 ||
                    cur_instr[31:25] == 7'b0100000) begin
                    ref_rs1_req  = 1'b1;
                    ref_rs2_req  = 1'b1;
                    ref_rd_write = 1'b1;
                    if (cur_instr[31:25] != 7'b0000001) ref_eu = 3;
                    else ref_eu = (cur_instr[14:12] < 3'd4) ? 4 : 5;   // mul vs div
                end else begin
                    ref_exc = 1'b1;
                end
            end
            MISC_MEM: ref_res_ready = 1'b1;   // fence
            SYSTEM: begin
                ref_exc = 1'b1;
                if (cur_instr == 32'h0000_0073) ref_code = E_ENV_CALL_M;
                else if (cur_instr == 32'h0010_0073) ref_code = E_BREAKPOINT;
            end
            default: ref_exc = 1'b1;
        endcase
        if (ref_exc) begin
            ref_res_ready = 1'b1;
            ref_stall     = 1'b1;
        end
    end

    task automatic expect_eq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    // {ready, value} of one source by the priority rules
    function automatic logic [XLEN:0] resolve_operand(input logic req, input logic busy,
        input logic [XLEN-1:0] rf_value, input logic rob_rdy, input logic [XLEN-1:0] rob_value,
        input logic [ROB_IDX_LEN-1:0] producer);
        if (!req) return '0;
        if (!busy) return {1'b1, rf_value};
        if (rob_rdy) return {1'b1, rob_value};
        if (cdb_rob_idx_i == producer && !cdb_except_raised_i) return {1'b1, cdb_value_i};
        return '0;
    endfunction

    task automatic check_outputs();
        logic            issue;
        logic [EU_N-1:0] exp_valid;
        logic [XLEN:0]   op1;
        logic [XLEN:0]   op2;
        logic [XLEN-1:0] exp_rs2;
        logic [I_IMM-1:0] exp_imm;
        logic            exp_exc;
        logic [3:0]      exp_code;
        issue = iq_valid_i && rob_ready_i && regstat_ready_i &&
                ((ref_eu < 0) ? 1'b1 : ex_ready_i[ref_eu]);
        exp_valid = '0;
        if (issue && ref_eu >= 0) exp_valid[ref_eu] = 1'b1;
        op1 = resolve_operand(ref_rs1_req, regstat_rs1_busy_i, rf_rs1_value_i, rob_rs1_ready_i,
                              rob_rs1_value_i, regstat_rs1_rob_idx_i);
        op2 = resolve_operand(ref_rs2_req, regstat_rs2_busy_i, rf_rs2_value_i, rob_rs2_ready_i,
                              rob_rs2_value_i, regstat_rs2_rob_idx_i);
        case (ref_imm_fmt)
            IMM_S:   exp_imm = {cur_instr[31:25], cur_instr[11:7]};
            IMM_B:   exp_imm = {cur_instr[31], cur_instr[7], cur_instr[30:25], cur_instr[11:8]};
            default: exp_imm = cur_instr[31:20];
        endcase
        if (ref_eu < 0 || ref_eu > 2) exp_imm = '0;   // imm port is for load, store, branch
        if (ref_eu == 3 && ref_imm_fmt == IMM_SHAMT) exp_rs2 = {58'b0, cur_instr[25:20]};
        else if (ref_eu == 3 && ref_imm_req) exp_rs2 = {{52{cur_instr[31]}}, cur_instr[31:20]};
        else exp_rs2 = op2[XLEN-1:0];
        exp_exc  = iq_entry_i.except_raised || ref_exc;   // fetch fault is older
        exp_code = iq_entry_i.except_raised ? iq_entry_i.except_code : ref_code;
        expect_eq(iq_ready_o, issue, "iq_ready_o");
        expect_eq(rob_valid_o, issue, "rob_valid_o");
        expect_eq(ex_valid_o, exp_valid, "ex_valid_o");
        expect_eq(regstat_valid_o, issue && ref_rd_write, "regstat_valid_o");
        expect_eq(ex_eu_ctl_o, ref_ctl, "ex_eu_ctl_o");
        expect_eq(ex_rs1_ready_o, op1[XLEN], "ex_rs1_ready_o");
        expect_eq(ex_rs1_value_o, op1[XLEN-1:0], "ex_rs1_value_o");
        expect_eq(ex_rs2_ready_o, op2[XLEN], "ex_rs2_ready_o");
        expect_eq(ex_rs2_value_o, exp_rs2, "ex_rs2_value_o");
        expect_eq(ex_imm_value_o, exp_imm, "ex_imm_value_o");
        expect_eq(rob_except_raised_o, exp_exc, "rob_except_raised_o");
        if (exp_exc) expect_eq(rob_except_code_o, exp_code, "rob_except_code_o");
        expect_eq(rob_except_aux_o, iq_entry_i.pc, "rob_except_aux_o");
        expect_eq(main_cu_stall_o, exp_exc || ref_stall, "main_cu_stall_o");
        expect_eq(rob_res_ready_o, ref_res_ready, "rob_res_ready_o");
        expect_eq(regstat_rs1_idx_o, cur_instr[19:15], "regstat_rs1_idx_o");
        expect_eq(regstat_rs2_idx_o, cur_instr[24:20], "regstat_rs2_idx_o");
        expect_eq(regstat_rd_idx_o, cur_instr[11:7], "regstat_rd_idx_o");
        expect_eq(rf_rs1_idx_o, cur_instr[19:15], "rf_rs1_idx_o");
        expect_eq(rf_rs2_idx_o, cur_instr[24:20], "rf_rs2_idx_o");
        expect_eq(regstat_rob_idx_o, rob_tail_idx_i, "regstat_rob_idx_o");
        expect_eq(ex_rob_idx_o, rob_tail_idx_i, "ex_rob_idx_o");
        expect_eq(rob_rs1_idx_o, regstat_rs1_rob_idx_i, "rob_rs1_idx_o");
        expect_eq(rob_rs2_idx_o, regstat_rs2_rob_idx_i, "rob_rs2_idx_o");
        expect_eq(ex_rs1_idx_o, regstat_rs1_rob_idx_i, "ex_rs1_idx_o");
        expect_eq(ex_rs2_idx_o, regstat_rs2_rob_idx_i, "ex_rs2_idx_o");
        expect_eq(ex_pred_pc_o, iq_entry_i.pc, "ex_pred_pc_o");
        expect_eq(ex_pred_target_o, iq_entry_i.pred_target, "ex_pred_target_o");
        expect_eq(ex_pred_taken_o, iq_entry_i.pred_taken, "ex_pred_taken_o");
        expect_eq(rob_instr_o, cur_instr, "rob_instr_o");
        expect_eq(rob_rd_idx_o, cur_instr[11:7], "rob_rd_idx_o");
    endtask

    // kind 0 load, 1 store, 2 branch, 3 op-imm, 4 op, 5 mul/div, 6 fence, 7 ecall, 8 ebreak
    function automatic logic [ILEN-1:0] make_instr(input int kind);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        rd  = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        f3  = 3'($urandom);
        imm = 12'($urandom);
        case (kind)
            0: return {imm, rs1, f3, rd, LOAD};
            1: return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
            2: return {imm[11:5], rs2, rs1, f3, imm[4:0], BRANCH};
            3: return {imm, rs1, f3, rd, OP_IMM};
            4: return {($urandom % 2 == 0) ? 7'b0000000 : 7'b0100000, rs2, rs1, f3, rd, OP};
            5: return {7'b0000001, rs2, rs1, f3, rd, OP};
            6: return {imm, rs1, 3'b000, rd, MISC_MEM};
            7: return 32'h0000_0073;
            8: return 32'h0010_0073;
            default: begin   // lui, jal or a 32-bit W op
                case ($urandom % 3)
                    0: return {25'($urandom), 7'b0110111};
                    1: return {25'($urandom), 7'b1101111};
                    default: return {25'($urandom), 7'b0111011};
                endcase
            end
        endcase
    endfunction

    task automatic apply_vector(input int kind, input bit random_ready, input bit fetch_exc);
        int cdb_pick;
        @(posedge clk);
        #2;
        iq_entry_i.instr         = make_instr(kind);
        iq_entry_i.pc            = {$urandom, $urandom};
        iq_entry_i.pred_target   = {$urandom, $urandom};
        iq_entry_i.pred_taken    = 1'($urandom);
        iq_entry_i.except_raised = fetch_exc;
        case ($urandom % 3)
            0: iq_entry_i.except_code = E_I_ADDR_MISALIGNED;
            1: iq_entry_i.except_code = E_I_ACCESS_FAULT;
            default: iq_entry_i.except_code = E_I_PAGE_FAULT;
        endcase
        iq_valid_i      = random_ready ? ($urandom % 5 != 0) : 1'b1;
        rob_ready_i     = random_ready ? ($urandom % 4 != 0) : 1'b1;
        regstat_ready_i = random_ready ? ($urandom % 4 != 0) : 1'b1;
        ex_ready_i      = random_ready ? EU_N'($urandom | $urandom) : '1;   // ~3/4 per bit
        regstat_rs1_busy_i    = 1'($urandom);
        regstat_rs2_busy_i    = 1'($urandom);
        regstat_rs1_rob_idx_i = ROB_IDX_LEN'($urandom);
        regstat_rs2_rob_idx_i = ROB_IDX_LEN'($urandom);
        rf_rs1_value_i  = {$urandom, $urandom};
        rf_rs2_value_i  = {$urandom, $urandom};
        rob_rs1_ready_i = 1'($urandom);
        rob_rs2_ready_i = 1'($urandom);
        rob_rs1_value_i = {$urandom, $urandom};
        rob_rs2_value_i = {$urandom, $urandom};
        rob_tail_idx_i  = ROB_IDX_LEN'($urandom);
        cdb_pick = $urandom % 3;   // hit rs1, hit rs2 or likely miss
        cdb_rob_idx_i = (cdb_pick == 0) ? regstat_rs1_rob_idx_i :
                        (cdb_pick == 1) ? regstat_rs2_rob_idx_i : ROB_IDX_LEN'($urandom);
        cdb_value_i         = {$urandom, $urandom};
        cdb_except_raised_i = ($urandom % 4 == 0);
    endtask

    task automatic run_test(input int test_no, input string name, inout int passed,
                            inout int failed);
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < VECTORS; i++) begin
            case (test_no)
                1: apply_vector(i % 10, 1'b0, 1'b0);
                2: apply_vector(int'($urandom % 10), 1'b1, 1'b0);
                3: apply_vector((i % 4 < 2) ? 1 + i % 4 : 2 + i % 4, 1'b0, 1'b0);   // 2-source
                4: apply_vector(i % 4, 1'b0, 1'b0);
                5: apply_vector(int'($urandom % 10), 1'b0, 1'b1);
                default: apply_vector(i % 6, 1'b1, 1'b0);
            endcase
        end
        @(posedge clk);   // last vector was checked on the falling edge before this
        if (error_count == errors_before) begin
            passed++;
            $display("test %0d %s: ok", test_no, name);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", test_no, name, error_count - errors_before);
        end
    endtask

    always @(negedge clk) begin
        if (!reset_i) check_outputs();
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: tests did not complete");
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int seed_value;
        int passed;
        int failed;
        seed_value = $urandom(70232);
        passed = 0;
        failed = 0;
        reset_i = 1'b1;
        iq_valid_i = 1'b0;
        iq_entry_i = '0;
        regstat_ready_i = 1'b0;
        rob_ready_i = 1'b0;
        regstat_rs1_busy_i = 1'b0;
        regstat_rs2_busy_i = 1'b0;
        regstat_rs1_rob_idx_i = '0;
        regstat_rs2_rob_idx_i = '0;
        rf_rs1_value_i = '0;
        rf_rs2_value_i = '0;
        ex_ready_i = '0;
        rob_rs1_ready_i = 1'b0;
        rob_rs2_ready_i = 1'b0;
        rob_rs1_value_i = '0;
        rob_rs2_value_i = '0;
        rob_tail_idx_i = '0;
        cdb_rob_idx_i = '0;
        cdb_value_i = '0;
        cdb_except_raised_i = 1'b0;
        repeat (4) @(posedge clk);
        #2 reset_i = 1'b0;
        run_test(1, "decode", passed, failed);
        run_test(2, "back-pressure", passed, failed);
        run_test(3, "operand sources", passed, failed);
        run_test(4, "immediates", passed, failed);
        run_test(5, "exceptions", passed, failed);
        run_test(6, "register status", passed, failed);
        $display("tests passed: %0d, failed: %0d, check errors: %0d", passed, failed,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* issue_logic.sv */
module issue_logic import issue_pkg::*; #(
    parameter int ROB_IDX_LEN = 6
) (
    // issue queue
    input  logic                   iq_valid_i,
    input  iq_entry_t              iq_entry_i,
    output logic                   iq_ready_o,
    // register status table
    input  logic                   regstat_ready_i,
    output logic                   regstat_valid_o,
    input  logic                   regstat_rs1_busy_i,
    input  logic [ROB_IDX_LEN-1:0] regstat_rs1_rob_idx_i,
    input  logic                   regstat_rs2_busy_i,
    input  logic [ROB_IDX_LEN-1:0] regstat_rs2_rob_idx_i,
    output logic [REG_IDX_LEN-1:0] regstat_rd_idx_o,
    output logic [ROB_IDX_LEN-1:0] regstat_rob_idx_o,   // ROB tail gets rd
    output logic [REG_IDX_LEN-1:0] regstat_rs1_idx_o,
    output logic [REG_IDX_LEN-1:0] regstat_rs2_idx_o,
    // register file
    input  logic [XLEN-1:0]        rf_rs1_value_i,
    input  logic [XLEN-1:0]        rf_rs2_value_i,
    output logic [REG_IDX_LEN-1:0] rf_rs1_idx_o,
    output logic [REG_IDX_LEN-1:0] rf_rs2_idx_o,
    // reservation stations
    input  logic [EU_N-1:0]        ex_ready_i,
    output logic [EU_N-1:0]        ex_valid_o,
    output logic [EU_CTL_LEN-1:0]  ex_eu_ctl_o,
    output logic                   ex_rs1_ready_o,
    output logic [ROB_IDX_LEN-1:0] ex_rs1_idx_o,        // tag to wait on if not ready
    output logic [XLEN-1:0]        ex_rs1_value_o,
    output logic                   ex_rs2_ready_o,
    output logic [ROB_IDX_LEN-1:0] ex_rs2_idx_o,
    output logic [XLEN-1:0]        ex_rs2_value_o,
    output logic [I_IMM-1:0]       ex_imm_value_o,
    output logic [ROB_IDX_LEN-1:0] ex_rob_idx_o,
    output logic [XLEN-1:0]        ex_pred_pc_o,        // branch unit only
    output logic [XLEN-1:0]        ex_pred_target_o,
    output logic                   ex_pred_taken_o,
    // ROB
    input  logic                   rob_ready_i,
    output logic                   rob_valid_o,
    input  logic                   rob_rs1_ready_i,
    input  logic [XLEN-1:0]        rob_rs1_value_i,
    input  logic                   rob_rs2_ready_i,
    input  logic [XLEN-1:0]        rob_rs2_value_i,
    input  logic [ROB_IDX_LEN-1:0] rob_tail_idx_i,
    output logic [ROB_IDX_LEN-1:0] rob_rs1_idx_o,
    output logic [ROB_IDX_LEN-1:0] rob_rs2_idx_o,
    output logic [ILEN-1:0]        rob_instr_o,
    output logic [REG_IDX_LEN-1:0] rob_rd_idx_o,
    output logic                   rob_except_raised_o,
    output except_code_t           rob_except_code_o,
    output logic [XLEN-1:0]        rob_except_aux_o,
    output logic                   rob_res_ready_o,
    // CDB
    input  logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i,
    input  logic [XLEN-1:0]        cdb_value_i,
    input  logic                   cdb_except_raised_i,
    // main control
    output logic                   main_cu_stall_o
);

    logic [ILEN-1:0]        instr;
    logic [REG_IDX_LEN-1:0] rs1_idx;
    logic [REG_IDX_LEN-1:0] rs2_idx;
    logic [REG_IDX_LEN-1:0] rd_idx;
    dec_info_t              dec;
    logic [XLEN-1:0]        rs1_value;
    logic [XLEN-1:0]        rs2_value;

    assign instr   = iq_entry_i.instr;
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rd_idx  = instr[11:7];

    // same indices go to the regstat table and the RF
    assign regstat_rs1_idx_o = rs1_idx;
    assign regstat_rs2_idx_o = rs2_idx;
    assign regstat_rd_idx_o  = rd_idx;
    assign regstat_rob_idx_o = rob_tail_idx_i;
    assign rf_rs1_idx_o      = rs1_idx;
    assign rf_rs2_idx_o      = rs2_idx;

    // producers are looked up in the ROB and named to the RS
    assign rob_rs1_idx_o = regstat_rs1_rob_idx_i;
    assign rob_rs2_idx_o = regstat_rs2_rob_idx_i;
    assign ex_rs1_idx_o  = regstat_rs1_rob_idx_i;
    assign ex_rs2_idx_o  = regstat_rs2_rob_idx_i;

    assign rob_instr_o      = instr;
    assign rob_rd_idx_o     = rd_idx;
    assign rob_res_ready_o  = dec.res_ready;
    assign ex_eu_ctl_o      = dec.eu_ctl;
    assign ex_rob_idx_o     = rob_tail_idx_i;
    assign ex_pred_pc_o     = iq_entry_i.pc;
    assign ex_pred_target_o = iq_entry_i.pred_target;
    assign ex_pred_taken_o  = iq_entry_i.pred_taken;

    issue_decoder u_issue_decoder (
        .instr_i (instr),
        .dec_o   (dec)
    );

    operand_fetch #(.ROB_IDX_LEN(ROB_IDX_LEN)) u_rs1_fetch (
        .req_i          (dec.rs1_req),
        .busy_i         (regstat_rs1_busy_i),
        .rf_value_i     (rf_rs1_value_i),
        .rob_ready_i    (rob_rs1_ready_i),
        .rob_value_i    (rob_rs1_value_i),
        .producer_idx_i (regstat_rs1_rob_idx_i),
        .cdb_rob_idx_i  (cdb_rob_idx_i),
        .cdb_value_i    (cdb_value_i),
        .cdb_except_i   (cdb_except_raised_i),
        .ready_o        (ex_rs1_ready_o),
        .value_o        (rs1_value)
    );

    operand_fetch #(.ROB_IDX_LEN(ROB_IDX_LEN)) u_rs2_fetch (
        .req_i          (dec.rs2_req),
        .busy_i         (regstat_rs2_busy_i),
        .rf_value_i     (rf_rs2_value_i),
        .rob_ready_i    (rob_rs2_ready_i),
        .rob_value_i    (rob_rs2_value_i),
        .producer_idx_i (regstat_rs2_rob_idx_i),
        .cdb_rob_idx_i  (cdb_rob_idx_i),
        .cdb_value_i    (cdb_value_i),
        .cdb_except_i   (cdb_except_raised_i),
        .ready_o        (ex_rs2_ready_o),
        .value_o        (rs2_value)
    );

    operand_select u_operand_select (
        .instr_i        (instr),
        .dec_i          (dec),
        .rs1_value_i    (rs1_value),
        .rs2_value_i    (rs2_value),
        .ex_rs1_value_o (ex_rs1_value_o),
        .ex_rs2_value_o (ex_rs2_value_o),
        .ex_imm_value_o (ex_imm_value_o)
    );

    issue_ctrl u_issue_ctrl (
        .iq_i            (iq_entry_i),
        .iq_valid_i      (iq_valid_i),
        .dec_i           (dec),
        .rob_ready_i     (rob_ready_i),
        .regstat_ready_i (regstat_ready_i),
        .ex_ready_i      (ex_ready_i),
        .iq_ready_o      (iq_ready_o),
        .rob_valid_o     (rob_valid_o),
        .ex_valid_o      (ex_valid_o),
        .regstat_valid_o (regstat_valid_o),
        .except_raised_o (rob_except_raised_o),
        .except_code_o   (rob_except_code_o),
        .except_aux_o    (rob_except_aux_o),
        .stall_o         (main_cu_stall_o)
    );

endmodule

/* issue_ctrl.sv */
module issue_ctrl import issue_pkg::*; (
    input  iq_entry_t       iq_i,
    input  logic            iq_valid_i,
    input  dec_info_t       dec_i,
    input  logic            rob_ready_i,
    input  logic            regstat_ready_i,
    input  logic [EU_N-1:0] ex_ready_i,
    output logic            iq_ready_o,
    output logic            rob_valid_o,
    output logic [EU_N-1:0] ex_valid_o,
    output logic            regstat_valid_o,
    output logic            except_raised_o,
    output except_code_t    except_code_o,
    output logic [XLEN-1:0] except_aux_o,
    output logic            stall_o
);

    logic to_rs;      // instr needs a reservation station
    logic rs_ready;
    logic issue;

    assign to_rs    = (dec_i.eu != EU_NONE);
    assign rs_ready = !to_rs || ex_ready_i[dec_i.eu];   // ROB-only instrs skip the RS check
    assign issue    = iq_valid_i && rob_ready_i && regstat_ready_i && rs_ready;

    assign iq_ready_o      = issue;   // pop the queue head
    assign rob_valid_o     = issue;
    assign regstat_valid_o = issue && dec_i.regstat_upd;

    always_comb begin
        ex_valid_o = '0;
        if (issue && to_rs) begin
            ex_valid_o[dec_i.eu] = 1'b1;
        end
    end

    // fetch exception is older, so it hides whatever decode found
    always_comb begin
        if (iq_i.except_raised) begin
            except_raised_o = 1'b1;
            except_code_o   = iq_i.except_code;
        end else if (dec_i.except_raised) begin
            except_raised_o = 1'b1;
            except_code_o   = dec_i.except_code;
        end else begin
            except_raised_o = 1'b0;
            except_code_o   = iq_i.except_code;   // ignored by the ROB
        end
    end

    assign except_aux_o = iq_i.pc;   // faulting pc
    assign stall_o      = except_raised_o || dec_i.stall_possible;

endmodule

/* operand_select.sv */
module operand_select import issue_pkg::*; (
    input  logic [ILEN-1:0]  instr_i,
    input  dec_info_t        dec_i,
    input  logic [XLEN-1:0]  rs1_value_i,
    input  logic [XLEN-1:0]  rs2_value_i,
    output logic [XLEN-1:0]  ex_rs1_value_o,
    output logic [XLEN-1:0]  ex_rs2_value_o,
    output logic [I_IMM-1:0] ex_imm_value_o
);

    logic [I_IMM-1:0] imm_i;
    logic [I_IMM-1:0] imm_s;
    logic [I_IMM-1:0] imm_b;
    logic [I_IMM-1:0] imm;
    logic [XLEN-1:0]  alu_imm;

    assign imm_i = instr_i[31:20];
    assign imm_s = {instr_i[31:25], instr_i[11:7]};
    assign imm_b = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8]};   // bit 0 implied

    always_comb begin
        case (dec_i.imm_format)
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            default: imm = imm_i;   // I and shamt share the field
        endcase
    end

    // ALU second operand from the immediate, shamt is 6 bits on RV64
    assign alu_imm = (dec_i.imm_format == IMM_SHAMT) ?
                     {{(XLEN-6){1'b0}}, imm_i[5:0]} :
                     {{(XLEN-I_IMM){imm_i[I_IMM-1]}}, imm_i};

    always_comb begin
        ex_rs1_value_o = '0;
        ex_rs2_value_o = '0;
        ex_imm_value_o = '0;
        case (dec_i.eu)
            EU_LOAD_BUFFER: begin
                ex_rs1_value_o = rs1_value_i;   // base
                ex_imm_value_o = imm;           // offset
            end
            EU_STORE_BUFFER, EU_BRANCH_UNIT: begin
                ex_rs1_value_o = rs1_value_i;
                ex_rs2_value_o = rs2_value_i;
                ex_imm_value_o = imm;           // store offset or branch displacement
            end
            EU_INT_ALU: begin
                ex_rs1_value_o = rs1_value_i;
                ex_rs2_value_o = dec_i.imm_req ? alu_imm : rs2_value_i;
            end
            EU_INT_MULT, EU_INT_DIV: begin
                ex_rs1_value_o = rs1_value_i;
                ex_rs2_value_o = rs2_value_i;
            end
            default: ;   // EU_NONE carries no operands
        endcase
    end

endmodule

/* operand_fetch.sv */
module operand_fetch import issue_pkg::*; #(
    parameter int ROB_IDX_LEN = 6
) (
    input  logic                   req_i,
    input  logic                   busy_i,           // a ROB entry still owns the register
    input  logic [XLEN-1:0]        rf_value_i,
    input  logic                   rob_ready_i,
    input  logic [XLEN-1:0]        rob_value_i,
    input  logic [ROB_IDX_LEN-1:0] producer_idx_i,
    input  logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i,
    input  logic [XLEN-1:0]        cdb_value_i,
    input  logic                   cdb_except_i,
    output logic                   ready_o,
    output logic [XLEN-1:0]        value_o
);

    logic cdb_hit;

    // producer result on the CDB this cycle, a faulting result is no operand
    assign cdb_hit = (cdb_rob_idx_i == producer_idx_i) && !cdb_except_i;

    always_comb begin
        ready_o = 1'b0;
        value_o = '0;
        if (req_i) begin
            if (!busy_i) begin
                ready_o = 1'b1;
                value_o = rf_value_i;    // committed value
            end else if (rob_ready_i) begin
                ready_o = 1'b1;
                value_o = rob_value_i;   // done, not yet committed
            end else if (cdb_hit) begin
                ready_o = 1'b1;
                value_o = cdb_value_i;   // being broadcast right now
            end
            // else the RS waits on producer_idx_i
        end
    end

endmodule

/* issue_decoder.sv */
module issue_decoder import issue_pkg::*; (
    input  logic [ILEN-1:0] instr_i,
    output dec_info_t       dec_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        // illegal-free defaults, nothing requested
        dec_o                = '0;
        dec_o.eu             = EU_NONE;
        dec_o.imm_format     = IMM_I;
        dec_o.except_code    = E_ILLEGAL_INSTR;
        dec_o.eu_ctl[2:0]    = funct3;    // funct3 always in the low bits

        case (opcode_t'(instr_i[6:0]))
            LOAD: begin
                dec_o.eu          = EU_LOAD_BUFFER;
                dec_o.rs1_req     = 1'b1;
                dec_o.imm_req     = 1'b1;
                dec_o.regstat_upd = 1'b1;
            end
            STORE: begin   // no rd, so no regstat update
                dec_o.eu         = EU_STORE_BUFFER;
                dec_o.rs1_req    = 1'b1;
                dec_o.rs2_req    = 1'b1;
                dec_o.imm_req    = 1'b1;
                dec_o.imm_format = IMM_S;
            end
            BRANCH: begin
                dec_o.eu         = EU_BRANCH_UNIT;
                dec_o.rs1_req    = 1'b1;
                dec_o.rs2_req    = 1'b1;
                dec_o.imm_req    = 1'b1;
                dec_o.imm_format = IMM_B;
            end
            OP_IMM: begin
                dec_o.eu          = EU_INT_ALU;
                dec_o.rs1_req     = 1'b1;
                dec_o.imm_req     = 1'b1;
                dec_o.regstat_upd = 1'b1;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin   // slli, srli, srai
                    dec_o.imm_format = IMM_SHAMT;
                    dec_o.eu_ctl[3]  = instr_i[30];              // arithmetic shift
                end
            end
            OP: begin
                dec_o.rs1_req     = 1'b1;
                dec_o.rs2_req     = 1'b1;
                dec_o.regstat_upd = 1'b1;
                dec_o.eu_ctl[3]   = instr_i[30];   // sub / sra
                if (funct7 == 7'b0000001) begin
                    // mul* below funct3 4, div/rem from 4 up
                    dec_o.eu = (funct3 < 3'd4) ? EU_INT_MULT : EU_INT_DIV;
                end else if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                    dec_o.eu = EU_INT_ALU;
                end else begin
                    dec_o.rs1_req        = 1'b0;
                    dec_o.rs2_req        = 1'b0;
                    dec_o.regstat_upd    = 1'b0;
                    dec_o.except_raised  = 1'b1;
                    dec_o.res_ready      = 1'b1;
                    dec_o.stall_possible = 1'b1;
                end
            end
            MISC_MEM: begin
                dec_o.res_ready = 1'b1;   // fence just retires from the ROB
            end
            SYSTEM: begin
                dec_o.except_raised  = 1'b1;
                dec_o.res_ready      = 1'b1;
                dec_o.stall_possible = 1'b1;
                if (instr_i == 32'h0000_0073) begin
                    dec_o.except_code = E_ENV_CALL_M;   // ecall
                end else if (instr_i == 32'h0010_0073) begin
                    dec_o.except_code = E_BREAKPOINT;   // ebreak
                end
            end
            default: begin   // anything else, incl. lui/auipc/jal/jalr and *W ops
                dec_o.except_raised  = 1'b1;
                dec_o.res_ready      = 1'b1;
                dec_o.stall_possible = 1'b1;
            end
        endcase
    end

endmodule

/* issue_pkg.sv */
package issue_pkg;

    localparam int XLEN        = 64;  // RV64 data width
    localparam int ILEN        = 32;
    localparam int REG_IDX_LEN = 5;
    localparam int I_IMM       = 12;  // I, S and B immediates share this width
    localparam int EU_CTL_LEN  = 8;
    localparam int EU_N        = 6;   // reservation stations

    // major opcodes handled by the integer issue stage
    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        BRANCH   = 7'b1100011,
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        MISC_MEM = 7'b0001111,
        SYSTEM   = 7'b1110011
    } opcode_t;

    // the value of each unit is its bit in ex_valid_o / ex_ready_i
    typedef enum logic [2:0] {
        EU_LOAD_BUFFER  = 3'd0,
        EU_STORE_BUFFER = 3'd1,
        EU_BRANCH_UNIT  = 3'd2,
        EU_INT_ALU      = 3'd3,
        EU_INT_MULT     = 3'd4,
        EU_INT_DIV      = 3'd5,
        EU_NONE         = 3'd6   // ROB only
    } issue_eu_t;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_SHAMT
    } imm_format_t;

    typedef enum logic [3:0] {
        E_I_ADDR_MISALIGNED = 4'd0,   // fetch side
        E_I_ACCESS_FAULT    = 4'd1,   // fetch side
        E_ILLEGAL_INSTR     = 4'd2,
        E_BREAKPOINT        = 4'd3,
        E_ENV_CALL_M        = 4'd11,
        E_I_PAGE_FAULT      = 4'd12   // fetch side
    } except_code_t;

    // head of the issue queue
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
        logic [XLEN-1:0] pred_target;
        logic            pred_taken;
        logic            except_raised;
        except_code_t    except_code;
    } iq_entry_t;

    // decoder result
    typedef struct packed {
        issue_eu_t             eu;
        logic [EU_CTL_LEN-1:0] eu_ctl;
        logic                  rs1_req;
        logic                  rs2_req;
        logic                  imm_req;
        imm_format_t           imm_format;
        logic                  regstat_upd;   // instr writes rd
        logic                  except_raised;
        except_code_t          except_code;
        logic                  res_ready;     // ROB entry ready to commit at once
        logic                  stall_possible;
    } dec_info_t;

endpackage
